// ==== hw/rob_pkg.sv ====
package rob_pkg;

  // default entry count, must be a power of two
  localparam int rob_depth = 8;

  typedef logic [4:0]  reg_addr_t;
  typedef logic [31:0] data_t;
  typedef logic [31:0] pc_t;
  typedef logic [4:0]  exc_code_t;

  // stored entry word, done flag in the top bit
  localparam int entry_w = 2 + $bits(reg_addr_t) + $bits(data_t) + $bits(pc_t)
                           + $bits(exc_code_t);
  localparam int done_bit = entry_w - 1;

  typedef logic [entry_w-1:0] entry_word_t;

  function automatic entry_word_t pack_entry(
    input logic      done,
    input logic      reg_write_en,
    input reg_addr_t reg_addr,
    input data_t     data,
    input pc_t       pc,
    input exc_code_t exc_code
  );
    return {done, reg_write_en, reg_addr, data, pc, exc_code};
  endfunction

endpackage

// ==== hw/rob_if.sv ====
// payload of one entry, driven by the top level
interface rob_entry_if;
  import rob_pkg::*;

  logic      done;
  logic      reg_write_en;
  reg_addr_t reg_addr;
  data_t     data;
  pc_t       pc;
  exc_code_t exc_code;

  // storage side
  modport sink (
    input done, reg_write_en, reg_addr, data, pc, exc_code
  );

  // read view, for same-cycle forwarding
  modport fwd (
    input done, reg_write_en, reg_addr, data, pc, exc_code
  );

endinterface

// ring positions as plain indices, wrap bits stay in the controller
interface rob_pos_if #(
  parameter int ROB_DEPTH = rob_pkg::rob_depth
);
  localparam int idx_w = $clog2(ROB_DEPTH);

  logic [idx_w-1:0] head_idx;
  logic [idx_w-1:0] read_idx;
  logic [idx_w-1:0] tail_idx;
  logic             alloc_fire;

  modport ctrl (
    output head_idx, read_idx, tail_idx, alloc_fire
  );

  modport user (
    input head_idx, read_idx, tail_idx, alloc_fire
  );

endinterface

// ==== hw/rob_ptr_ctrl.sv ====
module rob_ptr_ctrl #(
  parameter int  ROB_DEPTH = rob_pkg::rob_depth,
  localparam int idx_w     = $clog2(ROB_DEPTH)
) (
  input  logic             clk,
  input  logic             rst,
  input  logic             write_en,
  input  logic             read_en,
  input  logic             commit_en,
  input  logic             erase_en,
  input  logic [idx_w-1:0] erase_from_addr,
  input  logic             head_done,
  input  logic             update_hits_head,
  rob_pos_if.ctrl          pos,
  output logic             can_read,
  output logic             can_write,
  output logic             can_commit
);

  // index plus one wrap bit
  typedef logic [idx_w:0] ptr_t;

  ptr_t head_ptr;
  ptr_t read_ptr;
  ptr_t tail_ptr;
  ptr_t head_nxt;
  ptr_t read_adv;
  ptr_t read_nxt;
  ptr_t tail_nxt;
  ptr_t erase_cnt;
  ptr_t read_over;
  ptr_t adv_over;
  logic alloc_fire;
  logic erase_wrap;
  logic read_cut;
  logic full_after_commit;

  // erase blocks allocation
  assign alloc_fire = write_en && !erase_en;

  // an erase point below the head index has wrapped past the end of the ring
  assign erase_wrap = (erase_from_addr >= head_ptr[idx_w-1:0]) ? head_ptr[idx_w]
                                                               : ~head_ptr[idx_w];

  always_comb begin
    head_nxt = commit_en ? head_ptr + 1'b1 : head_ptr;
    if (erase_en) begin
      tail_nxt = {erase_wrap, erase_from_addr};
    end else if (alloc_fire) begin
      tail_nxt = tail_ptr + 1'b1;
    end else begin
      tail_nxt = tail_ptr;
    end
  end

  // number of entries dropped by this erase
  assign erase_cnt = tail_ptr - tail_nxt;

  // distance past the new tail, inside the erased span means cut off
  assign read_over = read_ptr - tail_nxt;
  assign read_cut  = erase_en && (read_over <= erase_cnt);

  assign read_adv = read_en ? read_ptr + 1'b1 : read_ptr;
  assign adv_over = read_adv - tail_nxt;

  always_comb begin
    read_nxt = read_adv;
    if (erase_en && (adv_over <= erase_cnt)) begin
      read_nxt = tail_nxt;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst) begin
      head_ptr <= '0;
      read_ptr <= '0;
      tail_ptr <= '0;
    end else begin
      head_ptr <= head_nxt;
      read_ptr <= read_nxt;
      tail_ptr <= tail_nxt;
    end
  end

  // full check against the head after this cycle's commit
  assign full_after_commit = (tail_ptr[idx_w] != head_nxt[idx_w])
                             && (tail_ptr[idx_w-1:0] == head_nxt[idx_w-1:0]);

  assign can_write  = !full_after_commit;
  assign can_read   = (read_ptr != tail_nxt) && !read_cut;
  assign can_commit = (head_ptr != tail_ptr) && (head_done || update_hits_head);

  assign pos.head_idx   = head_ptr[idx_w-1:0];
  assign pos.read_idx   = read_ptr[idx_w-1:0];
  assign pos.tail_idx   = tail_ptr[idx_w-1:0];
  assign pos.alloc_fire = alloc_fire;

endmodule

// ==== hw/rob_entry_array.sv ====
module rob_entry_array #(
  parameter int  ROB_DEPTH = rob_pkg::rob_depth,
  localparam int idx_w     = $clog2(ROB_DEPTH)
) (
  input  logic                                  clk,
  input  logic                                  rst,
  rob_pos_if.user                               pos,
  rob_entry_if.sink                             new_entry,
  input  logic                                  update_en,
  input  logic [idx_w-1:0]                      update_addr,
  output rob_pkg::entry_word_t [ROB_DEPTH-1:0]  entries,
  output logic                                  head_done
);
  import rob_pkg::*;

  entry_word_t      new_word;
  logic             wr_en;
  logic [idx_w-1:0] wr_idx;

  assign new_word = pack_entry(
    new_entry.done,
    new_entry.reg_write_en,
    new_entry.reg_addr,
    new_entry.data,
    new_entry.pc,
    new_entry.exc_code
  );

  // one payload bus, so an allocation shadows any update
  assign wr_en  = pos.alloc_fire || update_en;
  assign wr_idx = pos.alloc_fire ? pos.tail_idx : update_addr;

  always_ff @(posedge clk) begin
    if (!rst) begin
      entries <= '0;
    end else if (wr_en) begin
      entries[wr_idx] <= new_word;
    end
  end

  // stored state only, forwarding is handled in the read view
  assign head_done = entries[pos.head_idx][done_bit];

endmodule

// ==== hw/rob_read_view.sv ====
module rob_read_view #(
  parameter int  ROB_DEPTH = rob_pkg::rob_depth,
  localparam int idx_w     = $clog2(ROB_DEPTH)
) (
  rob_pos_if.user                              pos,
  input  logic                                 read_en,
  rob_entry_if.fwd                             new_entry,
  input  logic                                 update_en,
  input  logic [idx_w-1:0]                     update_addr,
  input  rob_pkg::entry_word_t [ROB_DEPTH-1:0] entries,
  output logic [idx_w-1:0]                     rob_addr,
  output logic                                 done,
  output logic                                 reg_write_en,
  output rob_pkg::reg_addr_t                   reg_addr,
  output rob_pkg::data_t                       data,
  output rob_pkg::pc_t                         pc,
  output rob_pkg::exc_code_t                   exc_code,
  output logic                                 update_hits_head
);
  import rob_pkg::*;

  logic [idx_w-1:0] view_idx;
  logic             fwd_hit;
  logic             upd_live;
  entry_word_t      new_word;
  entry_word_t      view_word;

  // issue stage sees the read position, otherwise retire sees the head
  assign view_idx = read_en ? pos.read_idx : pos.head_idx;

  // update is written only when no allocation takes the payload bus
  assign upd_live = update_en && !pos.alloc_fire;

  assign fwd_hit = (pos.alloc_fire && (pos.tail_idx == view_idx))
                   || (upd_live && (update_addr == view_idx));

  assign new_word = pack_entry(
    new_entry.done,
    new_entry.reg_write_en,
    new_entry.reg_addr,
    new_entry.data,
    new_entry.pc,
    new_entry.exc_code
  );

  assign view_word = fwd_hit ? new_word : entries[view_idx];

  assign rob_addr = view_idx;
  assign {done, reg_write_en, reg_addr, data, pc, exc_code} = view_word;

  // head marked done by an update landing this cycle
  assign update_hits_head = upd_live && (update_addr == pos.head_idx) && new_entry.done;

endmodule

// ==== hw/rob_top.sv ====
module rob_top #(
  parameter int  ROB_DEPTH = rob_pkg::rob_depth,
  localparam int idx_w     = $clog2(ROB_DEPTH)
) (
  input  logic               clk,
  input  logic               rst,
  // issue side
  input  logic               read_en,
  output logic               can_read,
  // allocation
  input  logic               write_en,
  output logic               can_write,
  // execution result
  input  logic               update_en,
  input  logic [idx_w-1:0]   update_addr,
  // retire
  input  logic               commit_en,
  output logic               can_commit,
  // flush
  input  logic               erase_en,
  input  logic [idx_w-1:0]   erase_from_addr,
  // entry payload in
  input  logic               done_in,
  input  logic               reg_write_en_in,
  input  rob_pkg::reg_addr_t reg_addr_in,
  input  rob_pkg::data_t     data_in,
  input  rob_pkg::pc_t       pc_in,
  input  rob_pkg::exc_code_t exc_code_in,
  // read or head view
  output logic [idx_w-1:0]   rob_addr_out,
  output logic               done_out,
  output logic               reg_write_en_out,
  output rob_pkg::reg_addr_t reg_addr_out,
  output rob_pkg::data_t     data_out,
  output rob_pkg::pc_t       pc_out,
  output rob_pkg::exc_code_t exc_code_out
);
  import rob_pkg::*;

  entry_word_t [ROB_DEPTH-1:0] entries;
  logic                        head_done;
  logic                        update_hits_head;

  rob_entry_if new_entry ();
  rob_pos_if #(.ROB_DEPTH(ROB_DEPTH)) pos ();

  assign new_entry.done         = done_in;
  assign new_entry.reg_write_en = reg_write_en_in;
  assign new_entry.reg_addr     = reg_addr_in;
  assign new_entry.data         = data_in;
  assign new_entry.pc           = pc_in;
  assign new_entry.exc_code     = exc_code_in;

  rob_ptr_ctrl #(.ROB_DEPTH(ROB_DEPTH)) ptr_ctrl_inst (
    .clk              (clk),
    .rst              (rst),
    .write_en         (write_en),
    .read_en          (read_en),
    .commit_en        (commit_en),
    .erase_en         (erase_en),
    .erase_from_addr  (erase_from_addr),
    .head_done        (head_done),
    .update_hits_head (update_hits_head),
    .pos              (pos.ctrl),
    .can_read         (can_read),
    .can_write        (can_write),
    .can_commit       (can_commit)
  );

  rob_entry_array #(.ROB_DEPTH(ROB_DEPTH)) entry_array_inst (
    .clk         (clk),
    .rst         (rst),
    .pos         (pos.user),
    .new_entry   (new_entry.sink),
    .update_en   (update_en),
    .update_addr (update_addr),
    .entries     (entries),
    .head_done   (head_done)
  );

  rob_read_view #(.ROB_DEPTH(ROB_DEPTH)) read_view_inst (
    .pos              (pos.user),
    .read_en          (read_en),
    .new_entry        (new_entry.fwd),
    .update_en        (update_en),
    .update_addr      (update_addr),
    .entries          (entries),
    .rob_addr         (rob_addr_out),
    .done             (done_out),
    .reg_write_en     (reg_write_en_out),
    .reg_addr         (reg_addr_out),
    .data             (data_out),
    .pc               (pc_out),
    .exc_code         (exc_code_out),
    .update_hits_head (update_hits_head)
  );

endmodule

// ==== tb/rob_assert.sv ====
module rob_assert #(
  parameter int IDX_W = 3
) (
  input logic             clk,
  input logic             rst,
  input logic             write_en,
  input logic             commit_en,
  input logic             erase_en,
  input logic [IDX_W-1:0] erase_from_addr,
  input logic             can_write,
  input logic             can_read,
  input logic             can_commit,
  input logic [IDX_W-1:0] head_idx
);

  localparam int depth = 2 ** IDX_W;

  int occupancy;
  int fail_count = 0;

  // entry count rebuilt from the handshakes
  always @(posedge clk) begin
    if (!rst) begin
      occupancy <= 0;
    end else if (erase_en) begin
      occupancy <= (int'(erase_from_addr) - int'(head_idx) + depth) % depth
                   - int'(commit_en);
    end else begin
      occupancy <= occupancy + int'(write_en) - int'(commit_en);
    end
  end

  // allocation only while there is room
  write_needs_room: assert property (
    @(posedge clk) disable iff (!rst) write_en |-> can_write
  ) else begin
    fail_count++;
    $error("write_en asserted while can_write is low");
  end

  commit_needs_entry: assert property (
    @(posedge clk) disable iff (!rst) can_commit |-> (occupancy != 0)
  ) else begin
    fail_count++;
    $error("can_commit high on an empty buffer");
  end

  // first cycle out of reset is empty
  empty_after_reset: assert property (
    @(posedge clk) $rose(rst) |-> (!can_read && !can_commit)
  ) else begin
    fail_count++;
    $error("can_read or can_commit high right after reset");
  end

endmodule

// ==== tb/rob_checker.sv ====
module rob_checker #(
  parameter int  ROB_DEPTH = rob_pkg::rob_depth,
  localparam int idx_w     = $clog2(ROB_DEPTH)
) (
  input logic               clk,
  input logic               rst,
  input logic               write_en,
  input logic               read_en,
  input logic               commit_en,
  input logic               update_en,
  input logic [idx_w-1:0]   update_addr,
  input logic               erase_en,
  input logic [idx_w-1:0]   erase_from_addr,
  input logic               done_in,
  input logic               reg_write_en_in,
  input rob_pkg::reg_addr_t reg_addr_in,
  input rob_pkg::data_t     data_in,
  input rob_pkg::pc_t       pc_in,
  input rob_pkg::exc_code_t exc_code_in,
  input logic               can_read,
  input logic               can_write,
  input logic               can_commit,
  input logic [idx_w-1:0]   rob_addr_out,
  input logic               done_out,
  input logic               reg_write_en_out,
  input rob_pkg::reg_addr_t reg_addr_out,
  input rob_pkg::data_t     data_out,
  input rob_pkg::pc_t       pc_out,
  input rob_pkg::exc_code_t exc_code_out
);
  import rob_pkg::*;

  // positions as unbounded counters, ring index is the value mod depth
  entry_word_t mem [ROB_DEPTH];
  int          m_head;
  int          m_read;
  int          m_tail;
  int          errors = 0;
  string       test_name = "reset";

  function automatic int ring(input int p);
    return p % ROB_DEPTH;
  endfunction

  task automatic check_val(input string field, input logic [79:0] exp, input logic [79:0] act);
    if (exp !== act) begin
      errors++;
      $display("[FAIL] %s %s: expected %0h, actual %0h", test_name, field, exp, act);
    end
  endtask

  always @(posedge clk) begin : model_step
    entry_word_t in_word;
    entry_word_t view_exp;
    entry_word_t view_act;
    logic        alloc;
    logic        upd_live;
    logic        head_ready;
    int          tail_next;
    int          view_idx;
    int          adv;
    if (!rst) begin
      m_head = 0;
      m_read = 0;
      m_tail = 0;
      for (int i = 0; i < ROB_DEPTH; i++) begin
        mem[i] = '0;
      end
    end else begin
      in_word  = {done_in, reg_write_en_in, reg_addr_in, data_in, pc_in, exc_code_in};
      alloc    = write_en && !erase_en;
      upd_live = update_en && !alloc;
      if (erase_en) begin
        tail_next = m_head + (int'(erase_from_addr) - ring(m_head) + ROB_DEPTH) % ROB_DEPTH;
      end else begin
        tail_next = m_tail + int'(alloc);
      end
      head_ready = mem[ring(m_head)][done_bit]
                   || (upd_live && int'(update_addr) == ring(m_head) && done_in);
      view_idx = read_en ? ring(m_read) : ring(m_head);
      if ((alloc && ring(m_tail) == view_idx) || (upd_live && int'(update_addr) == view_idx)) begin
        view_exp = in_word;
      end else begin
        view_exp = mem[view_idx];
      end
      view_act = {done_out, reg_write_en_out, reg_addr_out, data_out, pc_out, exc_code_out};

      check_val("can_write", 80'(m_tail - m_head - int'(commit_en) < ROB_DEPTH), 80'(can_write));
      check_val("can_read", 80'(m_read < tail_next), 80'(can_read));
      check_val("can_commit", 80'(m_tail > m_head && head_ready), 80'(can_commit));
      check_val("rob_addr", 80'(view_idx), 80'(rob_addr_out));
      check_val("view", 80'(view_exp), 80'(view_act));

      if (alloc) begin
        mem[ring(m_tail)] = in_word;
      end else if (update_en) begin
        mem[int'(update_addr)] = in_word;
      end
      adv = m_read + int'(read_en);
      // read position past the new tail falls back to it
      if (erase_en && adv > tail_next) begin
        adv = tail_next;
      end
      m_read = adv;
      m_head = m_head + int'(commit_en);
      m_tail = tail_next;
    end
  end

endmodule

// ==== tb/rob_tb.sv ====
module rob_tb;
  import rob_pkg::*;

  localparam int depth = rob_depth;
  localparam int idx_w = $clog2(depth);
  localparam int len_total = 20 + (2 * depth + 10) + 13 + 6 * depth + (4 * 13 + 2 * depth) + 400;
  localparam int cycle_limit = len_total + 100;

  logic             clk = 1'b0;
  logic             rst;
  logic             write_en;
  logic             read_en;
  logic             commit_en;
  logic             update_en;
  logic [idx_w-1:0] update_addr;
  logic             erase_en;
  logic [idx_w-1:0] erase_from_addr;
  logic             done_in;
  logic             reg_write_en_in;
  reg_addr_t        reg_addr_in;
  data_t            data_in;
  pc_t              pc_in;
  exc_code_t        exc_code_in;
  logic             can_read;
  logic             can_write;
  logic             can_commit;
  logic [idx_w-1:0] rob_addr_out;
  logic             done_out;
  logic             reg_write_en_out;
  reg_addr_t        reg_addr_out;
  data_t            data_out;
  pc_t              pc_out;
  exc_code_t        exc_code_out;

  logic [31:0] rng = 32'hf3bd0f0b;
  int          cycles = 0;
  int          err_base = 0;
  int          assert_base = 0;
  int          tests_run = 0;
  int          tests_failed = 0;

  rob_top #(.ROB_DEPTH(depth)) rob_top_inst (.*);
  rob_checker #(.ROB_DEPTH(depth)) checker_inst (.*);

  bind rob_top rob_assert #(.IDX_W(idx_w)) rob_assert_inst (
    .clk             (clk),
    .rst             (rst),
    .write_en        (write_en),
    .commit_en       (commit_en),
    .erase_en        (erase_en),
    .erase_from_addr (erase_from_addr),
    .can_write       (can_write),
    .can_read        (can_read),
    .can_commit      (can_commit),
    .head_idx        (pos.head_idx)
  );

  initial begin
    forever #4 clk = ~clk;
  end

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  always @(posedge clk) begin
    cycles++;
    if (cycles > cycle_limit) begin
      $display("timeout: run went past %0d cycles", cycle_limit);
      $display("Test failures found");
      $finish;
    end
  end

  // one cycle of stimulus with every request gated by its flag
  task automatic drive_cycle(input bit want_write, input bit want_read, input bit want_commit,
                             input bit want_update, input bit want_erase, input int upd_off,
                             input int done_mode);
    int count;
    int off;
    @(negedge clk);
    rng = xorshift(rng);
    data_in = rng;
    rng = xorshift(rng);
    pc_in = {rng[31:2], 2'b00};
    reg_addr_in = rng[4:0];
    exc_code_in = rng[9:5];
    reg_write_en_in = rng[10];
    done_in = (done_mode == 2) ? rng[11] : (done_mode == 1);
    write_en = 1'b0;
    read_en = 1'b0;
    commit_en = 1'b0;
    count = checker_inst.m_tail - checker_inst.m_head;
    rng = xorshift(rng);
    off = (upd_off < 0) ? int'(rng[15:0]) : upd_off;
    update_en = want_update;
    update_addr = idx_w'((checker_inst.m_head + off) % depth);
    erase_en = want_erase && (count > 0);
    erase_from_addr = '0;
    if (erase_en) begin
      erase_from_addr = idx_w'((checker_inst.m_head + int'(rng[23:16]) % count) % depth);
    end
    #1;
    if (want_commit && can_commit && !erase_en) begin
      commit_en = 1'b1;
    end
    #1;
    // keep the read position within two laps of the tail
    if (want_write && can_write
        && (checker_inst.m_tail + 1 - checker_inst.m_read) < 2 * depth) begin
      write_en = 1'b1;
    end
    #1;
    if (commit_en && !can_commit) begin
      write_en = 1'b0;
    end
    if (want_read && can_read) begin
      read_en = 1'b1;
    end
  endtask

  task automatic start_test(input string name);
    checker_inst.test_name = name;
    err_base = checker_inst.errors;
    assert_base = rob_top_inst.rob_assert_inst.fail_count;
  endtask

  task automatic end_test();
    int errs;
    @(posedge clk);
    #1;
    errs = checker_inst.errors - err_base
           + rob_top_inst.rob_assert_inst.fail_count - assert_base;
    tests_run++;
    if (errs != 0) begin
      tests_failed++;
    end
    $display("test %s finished with %0d failed checks", checker_inst.test_name, errs);
  endtask

  initial begin
    rst = 1'b0;
    write_en = 1'b0;
    read_en = 1'b0;
    commit_en = 1'b0;
    update_en = 1'b0;
    update_addr = '0;
    erase_en = 1'b0;
    erase_from_addr = '0;
    done_in = 1'b0;
    reg_write_en_in = 1'b0;
    reg_addr_in = '0;
    data_in = '0;
    pc_in = '0;
    exc_code_in = '0;
    repeat (3) @(negedge clk);
    rst = 1'b1;

    start_test("alloc_commit");
    for (int i = 0; i < 6; i++) drive_cycle(1, 0, 0, 0, 0, 0, 1);
    for (int i = 0; i < 14; i++) drive_cycle(0, 0, 1, 0, 0, 0, 1);
    end_test();

    start_test("full_flags");
    for (int i = 0; i < depth + 2; i++) drive_cycle(1, 0, 0, 0, 0, 0, 1);
    for (int i = 0; i < 4; i++) drive_cycle(1, 0, 1, 0, 0, 0, 1);
    for (int i = 0; i < depth + 4; i++) drive_cycle(0, 1, 1, 0, 0, 0, 1);
    end_test();

    start_test("commit_wait");
    for (int i = 0; i < 3; i++) drive_cycle(1, 0, 0, 0, 0, 0, 0);
    for (int i = 0; i < 3; i++) drive_cycle(0, 0, 1, 0, 0, 0, 0);
    for (int i = 0; i < 3; i++) drive_cycle(0, 0, 1, 1, 0, 0, 1);
    for (int i = 0; i < 4; i++) drive_cycle(0, 0, 1, 0, 0, 0, 1);
    end_test();

    start_test("read_order");
    for (int i = 0; i < 2 * depth; i++) drive_cycle(0, 1, 0, 0, 0, 0, 2);
    for (int i = 0; i < depth; i++) drive_cycle(1, 0, 0, 0, 0, 0, 2);
    for (int i = 0; i < depth; i++) drive_cycle(1, 1, 0, 1, 0, -1, 2);
    for (int i = 0; i < 2 * depth; i++) drive_cycle(0, 1, 1, 0, 0, 0, 2);
    end_test();

    start_test("erase");
    for (int r = 0; r < 4; r++) begin
      for (int j = 0; j < 6; j++) drive_cycle(1, 0, 0, 0, 0, 0, 1);
      for (int j = 0; j < 3; j++) drive_cycle(0, 1, 0, 0, 0, 0, 1);
      drive_cycle(0, 0, 0, 0, 1, 0, 1);
      for (int j = 0; j < 3; j++) drive_cycle(1, 1, 0, 0, 0, 0, 1);
    end
    for (int i = 0; i < 2 * depth; i++) drive_cycle(0, 1, 1, 0, 0, 0, 1);
    end_test();

    start_test("random_mix");
    for (int i = 0; i < 400; i++) begin
      rng = xorshift(rng);
      drive_cycle(rng[7:0] < 8'd154, rng[15:8] < 8'd128, rng[23:16] < 8'd128,
                  rng[27:24] < 4'd6, rng[31:28] == 4'd0, -1, 2);
    end
    end_test();

    $display("%0d tests run, %0d failed, %0d mismatches, %0d assertion failures",
             tests_run, tests_failed, checker_inst.errors,
             rob_top_inst.rob_assert_inst.fail_count);
    if (checker_inst.errors == 0 && rob_top_inst.rob_assert_inst.fail_count == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

// ==== rob_top.f ====
hw/rob_pkg.sv
hw/rob_if.sv
hw/rob_ptr_ctrl.sv
hw/rob_entry_array.sv
hw/rob_read_view.sv
hw/rob_top.sv
tb/rob_assert.sv
tb/rob_checker.sv
tb/rob_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= rob_tb
FLIST     ?= rob_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := $(shell grep -v '^+' $(FLIST))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FLIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "All tests passed!" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
